// File: list.f
+incdir+hw
hw/pkt_client_pkg.sv
hw/st_pipe_stage.sv
hw/pkt_gen.sv
hw/avst_to_axis_tx.sv
hw/axis_to_avst_rx.sv
hw/pkt_check.sv
hw/status_csr.sv
hw/pkt_client_top.sv
testbench/tb_pkt_client_top.sv

// File: Bender.yml
package:
  name: pkt_client

sources:
  - include_dirs:
      - hw
    files:
      - hw/pkt_client_pkg.sv
      - hw/st_pipe_stage.sv
      - hw/pkt_gen.sv
      - hw/avst_to_axis_tx.sv
      - hw/axis_to_avst_rx.sv
      - hw/pkt_check.sv
      - hw/status_csr.sv
      - hw/pkt_client_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_pkt_client_top.sv

// File: testbench/tb_pkt_client_top.sv
// testbench for the packet client top with wishbone tasks, axi loopback and stream checks
`timescale 1ns/1ns
`include "pkt_client_consts.svh"

module tb_pkt_client_top;

  logic                        app_ss_lite_clk = 1'b0;
  logic                        i_rst;
  logic                        i_tx_pll_locked;
  pkt_client_pkg::wb_req_t     wb_req;
  pkt_client_pkg::wb_rsp_t     wb_rsp;
  pkt_client_pkg::axis_beat_t  o_axis_tx;
  logic                        o_axis_tx_valid;
  logic                        i_axis_tx_ready;
  pkt_client_pkg::axis_beat_t  i_axis_rx;
  logic                        i_axis_rx_valid;
  logic                        o_axis_rx_ready;

  int          errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 32'hffff_ffff;
  int          tx_beat_idx = 0;
  int          tx_frames_seen = 0;
  int          cur_len = 64;
  logic        rand_ready = 1'b0;
  logic        corrupt_on = 1'b0;
  int          corrupt_at = 0;
  logic        ready_pat [0:1023];
  int          len_list [0:19];

  always #2 app_ss_lite_clk = !app_ss_lite_clk;

  pkt_client_top i_pkt_client_top (
    .app_ss_lite_clk (app_ss_lite_clk),
    .i_rst           (i_rst),
    .i_tx_pll_locked (i_tx_pll_locked),
    .i_wb            (wb_req),
    .o_wb            (wb_rsp),
    .o_axis_tx       (o_axis_tx),
    .o_axis_tx_valid (o_axis_tx_valid),
    .i_axis_tx_ready (i_axis_tx_ready),
    .i_axis_rx       (i_axis_rx),
    .i_axis_rx_valid (i_axis_rx_valid),
    .o_axis_rx_ready (o_axis_rx_ready)
  );

  // ----------------------------------------------------------------------
  // loopback, tx port straight into rx
  // ----------------------------------------------------------------------
  // rx only sees beats the tx side actually hands over
  assign i_axis_rx_valid = o_axis_tx_valid && i_axis_tx_ready;

  always_comb begin
    i_axis_rx = o_axis_tx;
    // one byte flipped on the first beat of the chosen frame
    if (corrupt_on && tx_frames_seen == corrupt_at && tx_beat_idx == 0) begin
      i_axis_rx.data[7:0] = ~o_axis_tx.data[7:0];
    end
  end

  // tx beat monitor, ready pattern and cycle limit
  always @(posedge app_ss_lite_clk) begin
    cycle_cnt       <= cycle_cnt + 1;
    i_axis_tx_ready <= rand_ready ? ready_pat[cycle_cnt % 1024] : 1'b1;
    if (o_axis_tx_valid && i_axis_tx_ready) begin
      if (o_axis_tx.last) begin
        tx_beat_idx    <= 0;
        tx_frames_seen <= tx_frames_seen + 1;
      end else begin
        tx_beat_idx <= tx_beat_idx + 1;
      end
    end
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic int beats_of(input int len);
    return (len + 7) / 8;
  endfunction

  // low lanes live on the closing beat
  function automatic logic [7:0] keep_for(input int len);
    int r;
    r = len % 8;
    if (r == 0) r = 8;
    return 8'hff >> (8 - r);
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error @ %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic write_reg(input logic [`WB_ADR_W-1:0] adr, input logic [31:0] dat);
    pkt_client_pkg::wb_req_t req;
    req = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = 1'b1;
    req.adr = adr;
    req.dat = dat;
    @(posedge app_ss_lite_clk);
    wb_req <= req;
    do @(negedge app_ss_lite_clk); while (!wb_rsp.ack);
    @(posedge app_ss_lite_clk);
    wb_req <= '0;
  endtask

  task automatic read_reg(input logic [`WB_ADR_W-1:0] adr, output logic [31:0] dat);
    pkt_client_pkg::wb_req_t req;
    req = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.adr = adr;
    @(posedge app_ss_lite_clk);
    wb_req <= req;
    // data valid while ack is up
    do @(negedge app_ss_lite_clk); while (!wb_rsp.ack);
    dat = wb_rsp.dat;
    @(posedge app_ss_lite_clk);
    wb_req <= '0;
  endtask

  // start a run, wait for done, then for every frame to land in the checker
  task automatic run_frames(input int len, input int frames, input logic corrupt, input int pick);
    logic [31:0] stat;
    logic [31:0] good;
    logic [31:0] bad;
    write_reg(`REG_LEN, 32'(len));
    cur_len    <= len;
    corrupt_on <= corrupt;
    corrupt_at <= tx_frames_seen + pick;
    write_reg(`REG_CTRL, {16'(frames), 15'h0, 1'b1});
    do read_reg(`REG_STAT, stat); while (!stat[0]);
    do begin
      read_reg(`REG_RXGOOD, good);
      read_reg(`REG_RXBAD, bad);
    end while (good + bad < 32'(frames));
  endtask

  task automatic finish_test(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      tests_passed++;
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", num, name, errors - err_before);
    end
  endtask

  // ----------------------------------------------------------------------
  // stream rules on the tx port
  // ----------------------------------------------------------------------
  a_tx_stable: assert property (@(posedge app_ss_lite_clk) disable iff (i_rst)
    o_axis_tx_valid && !i_axis_tx_ready |=> o_axis_tx_valid && $stable(o_axis_tx))
    else begin
      $display("stalled tx beat changed or dropped at %0t ns", $time);
      errors++;
    end

  a_tx_keep: assert property (@(posedge app_ss_lite_clk) disable iff (i_rst)
    o_axis_tx_valid && o_axis_tx.last |-> o_axis_tx.keep == keep_for(cur_len))
    else begin
      $display("** Error @ %0t ns: last keep 0x%0h for length %0d", $time,
               o_axis_tx.keep, cur_len);
      errors++;
    end

  // tlast exactly on the final beat of the frame
  a_tx_last: assert property (@(posedge app_ss_lite_clk) disable iff (i_rst)
    o_axis_tx_valid && i_axis_tx_ready |->
      (o_axis_tx.last == (tx_beat_idx + 1 == beats_of(cur_len))))
    else begin
      $display("tlast on beat %0d of a %0d byte frame at %0t ns", tx_beat_idx, cur_len, $time);
      errors++;
    end

  // checker side never stalls, so rx takes every looped back beat
  a_rx_ready: assert property (@(posedge app_ss_lite_clk) disable iff (i_rst)
    i_axis_rx_valid |-> o_axis_rx_ready)
    else begin
      $display("rx port not ready for a looped back beat at %0t ns", $time);
      errors++;
    end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0] rd;
    int          err0;
    int          total_beats;
    int          sum_tx;
    int          sum_good;
    int          sum_bad;
    void'($urandom(86484));
    i_rst           = 1'b1;
    i_tx_pll_locked = 1'b0;
    wb_req          = '0;
    i_axis_tx_ready = 1'b0;
    for (int i = 0; i < 1024; i++) ready_pat[i] = 1'($urandom % 2);
    // odd sizes plus both limits, the rest random
    len_list[0] = 61;
    len_list[1] = `PKT_LEN_MIN;
    len_list[2] = `PKT_LEN_MAX;
    for (int i = 3; i < 20; i++) len_list[i] = `PKT_LEN_MIN + int'($urandom % 293);
    total_beats = beats_of(64) + 5 * beats_of(100);
    for (int i = 0; i < 20; i++) total_beats += beats_of(len_list[i]);
    cycle_limit = 4 * total_beats + 2000;

    repeat (8) @(posedge app_ss_lite_clk);
    i_rst           <= 1'b0;
    i_tx_pll_locked <= 1'b1;

    err0 = errors;
    @(negedge app_ss_lite_clk);
    check_eq("tx valid after reset", 32'(o_axis_tx_valid), 0);
    check_eq("ack after reset", 32'(wb_rsp.ack), 0);
    read_reg(`REG_TXCNT, rd);
    check_eq("TXCNT", rd, 0);
    read_reg(`REG_RXGOOD, rd);
    check_eq("RXGOOD", rd, 0);
    read_reg(`REG_RXBAD, rd);
    check_eq("RXBAD", rd, 0);
    read_reg(`REG_STAT, rd);
    check_eq("STAT", rd, 0);
    finish_test(1, "reset values", err0);

    err0 = errors;
    write_reg(`REG_LEN, 32'd200);
    write_reg(`REG_CTRL, 32'h0025_0000);
    read_reg(`REG_LEN, rd);
    check_eq("LEN readback", rd, 32'd200);
    read_reg(`REG_CTRL, rd);
    check_eq("CTRL readback", rd, 32'h0025_0000);
    finish_test(2, "register readback", err0);

    err0 = errors;
    run_frames(64, 1, 1'b0, 0);
    read_reg(`REG_STAT, rd);
    check_eq("STAT done", rd, 32'd1);
    read_reg(`REG_TXCNT, rd);
    check_eq("TXCNT", rd, 1);
    read_reg(`REG_RXGOOD, rd);
    check_eq("RXGOOD", rd, 1);
    read_reg(`REG_RXBAD, rd);
    check_eq("RXBAD", rd, 0);
    finish_test(3, "single frame", err0);

    // counters restart per run, so totals add up here
    err0 = errors;
    sum_tx = 0;
    sum_good = 0;
    sum_bad = 0;
    rand_ready <= 1'b1;
    for (int i = 0; i < 20; i++) begin
      run_frames(len_list[i], 1, 1'b0, 0);
      read_reg(`REG_TXCNT, rd);
      sum_tx += int'(rd);
      read_reg(`REG_RXGOOD, rd);
      sum_good += int'(rd);
      read_reg(`REG_RXBAD, rd);
      sum_bad += int'(rd);
    end
    rand_ready <= 1'b0;
    check_eq("TXCNT total", 32'(sum_tx), 20);
    check_eq("RXGOOD total", 32'(sum_good), 20);
    check_eq("RXBAD total", 32'(sum_bad), 0);
    finish_test(4, "back-pressure", err0);

    err0 = errors;
    run_frames(100, 5, 1'b1, 2);
    corrupt_on <= 1'b0;
    read_reg(`REG_TXCNT, rd);
    check_eq("TXCNT", rd, 5);
    read_reg(`REG_RXGOOD, rd);
    check_eq("RXGOOD", rd, 4);
    read_reg(`REG_RXBAD, rd);
    check_eq("RXBAD", rd, 1);
    finish_test(5, "corrupted frame", err0);

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: hw/pkt_client_top.sv
// packet client top with reset conditioning, tx/rx stream paths and status block
`timescale 1ns/1ns
`include "pkt_client_consts.svh"

module pkt_client_top (
  input  logic                       app_ss_lite_clk,
  input  logic                       i_rst,
  input  logic                       i_tx_pll_locked,
  input  pkt_client_pkg::wb_req_t    i_wb,
  output pkt_client_pkg::wb_rsp_t    o_wb,
  output pkt_client_pkg::axis_beat_t o_axis_tx,
  output logic                       o_axis_tx_valid,
  input  logic                       i_axis_tx_ready,
  input  pkt_client_pkg::axis_beat_t i_axis_rx,
  input  logic                       i_axis_rx_valid,
  output logic                       o_axis_rx_ready
);

  logic [1:0]                  lock_sync;
  logic                        rst_q;
  logic                        chk_rst;
  pkt_client_pkg::gen_cfg_t    cfg;
  pkt_client_pkg::pkt_counts_t counts;
  logic                        busy;
  logic                        gen_valid;
  logic                        gen_ready;
  pkt_client_pkg::avst_beat_t  gen_beat;
  logic                        rx_valid;
  pkt_client_pkg::avst_beat_t  rx_beat;
  logic [`PKT_CNT_W-1:0]       tx_frames;
  logic [`PKT_CNT_W-1:0]       rx_good;
  logic [`PKT_CNT_W-1:0]       rx_bad;

  // ------------------------------------------------------------------
  // reset conditioning
  // ------------------------------------------------------------------
  // pll lock is async, two flops before use
  always_ff @(posedge app_ss_lite_clk) begin
    lock_sync <= {lock_sync[0], i_tx_pll_locked};
    rst_q     <= i_rst || !lock_sync[1];
  end

  // checker restarts its frame index and counts with each run
  assign chk_rst = rst_q || cfg.start;

  // ------------------------------------------------------------------
  // tx path
  // ------------------------------------------------------------------
  pkt_gen i_pkt_gen (
    .app_ss_lite_clk (app_ss_lite_clk),
    .i_rst           (rst_q),
    .i_cfg           (cfg),
    .o_valid         (gen_valid),
    .o_beat          (gen_beat),
    .i_ready         (gen_ready),
    .o_busy          (busy),
    .o_tx_frames     (tx_frames)
  );

  avst_to_axis_tx i_avst_to_axis_tx (
    .app_ss_lite_clk (app_ss_lite_clk),
    .i_rst           (rst_q),
    .i_valid         (gen_valid),
    .i_beat          (gen_beat),
    .o_ready         (gen_ready),
    .o_valid         (o_axis_tx_valid),
    .o_beat          (o_axis_tx),
    .i_ready         (i_axis_tx_ready)
  );

  // ------------------------------------------------------------------
  // rx path
  // ------------------------------------------------------------------
  axis_to_avst_rx i_axis_to_avst_rx (
    .app_ss_lite_clk (app_ss_lite_clk),
    .i_rst           (rst_q),
    .i_valid         (i_axis_rx_valid),
    .i_beat          (i_axis_rx),
    .o_ready         (o_axis_rx_ready),
    .o_valid         (rx_valid),
    .o_beat          (rx_beat)
  );

  pkt_check i_pkt_check (
    .app_ss_lite_clk (app_ss_lite_clk),
    .i_rst           (chk_rst),
    .i_valid         (rx_valid),
    .i_beat          (rx_beat),
    .o_rx_good       (rx_good),
    .o_rx_bad        (rx_bad)
  );

  // counters gathered for the status block
  assign counts.tx_frames = tx_frames;
  assign counts.rx_good   = rx_good;
  assign counts.rx_bad    = rx_bad;

  status_csr i_status_csr (
    .app_ss_lite_clk (app_ss_lite_clk),
    .i_rst           (rst_q),
    .i_wb            (i_wb),
    .o_wb            (o_wb),
    .o_cfg           (cfg),
    .i_counts        (counts),
    .i_busy          (busy)
  );

endmodule

// File: hw/status_csr.sv
// wishbone classic slave with generator control and frame counter registers
`timescale 1ns/1ns
`include "pkt_client_consts.svh"

module status_csr (
  input  logic                        app_ss_lite_clk,
  input  logic                        i_rst,
  input  pkt_client_pkg::wb_req_t     i_wb,
  output pkt_client_pkg::wb_rsp_t     o_wb,
  output pkt_client_pkg::gen_cfg_t    o_cfg,
  input  pkt_client_pkg::pkt_counts_t i_counts,
  input  logic                        i_busy
);

  logic [`PKT_CNT_W-1:0] frames_q;
  logic [`PKT_LEN_W-1:0] len_q;
  logic                  start_q;
  logic                  started_q;
  logic                  ack_q;
  logic [`WB_DAT_W-1:0]  dat_q;
  logic [`WB_DAT_W-1:0]  rd_data;
  logic                  req;

  // new request, not the tail of one already acked
  assign req = i_wb.cyc && i_wb.stb && !ack_q;

  always_comb begin
    case (i_wb.adr)
      `REG_CTRL:   rd_data = {frames_q, 16'h0};
      `REG_LEN:    rd_data = {{(`WB_DAT_W-`PKT_LEN_W){1'b0}}, len_q};
      `REG_TXCNT:  rd_data = {16'h0, i_counts.tx_frames};
      `REG_RXGOOD: rd_data = {16'h0, i_counts.rx_good};
      `REG_RXBAD:  rd_data = {16'h0, i_counts.rx_bad};
      // done once a run was started and has drained
      `REG_STAT:   rd_data = {30'h0, i_busy, started_q && !i_busy};
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge app_ss_lite_clk) begin
    if (i_rst) begin
      frames_q  <= '0;
      len_q     <= '0;
      start_q   <= 1'b0;
      started_q <= 1'b0;
      ack_q     <= 1'b0;
    end else begin
      ack_q     <= req;
      start_q   <= 1'b0;
      started_q <= started_q || start_q;
      if (req && i_wb.we) begin
        case (i_wb.adr)
          `REG_CTRL: begin
            // frame count high half, start in bit 0
            frames_q <= i_wb.dat[31:16];
            start_q  <= i_wb.dat[0];
          end
          `REG_LEN: len_q <= i_wb.dat[`PKT_LEN_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge app_ss_lite_clk) begin
    dat_q <= rd_data;
  end

  assign o_wb.ack     = ack_q;
  assign o_wb.dat     = dat_q;
  assign o_cfg.start  = start_q;
  assign o_cfg.frames = frames_q;
  assign o_cfg.len    = len_q;

  // master keeps the strobe up until it sees ack
  a_ack_in_cycle: assert property (@(posedge app_ss_lite_clk) disable iff (i_rst)
    o_wb.ack |-> i_wb.cyc && i_wb.stb)
    else $error("wishbone ack outside a bus cycle");

endmodule

// File: hw/pkt_check.sv
// received frame pattern and length checker with good and bad counters
`timescale 1ns/1ns
`include "pkt_client_consts.svh"

module pkt_check (
  input  logic                       app_ss_lite_clk,
  input  logic                       i_rst,
  input  logic                       i_valid,
  input  pkt_client_pkg::avst_beat_t i_beat,
  output logic [`PKT_CNT_W-1:0]      o_rx_good,
  output logic [`PKT_CNT_W-1:0]      o_rx_bad
);

  logic [7:0]             idx_q;
  logic [`PKT_LEN_W-1:0]  off_q;
  logic                   err_q;
  logic [`PKT_LEN_W-1:0]  base;
  logic [`PKT_LEN_W-1:0]  frame_len;
  logic [`PKT_KEEP_W-1:0] lane_en;
  logic                   mismatch;
  logic                   bad;

  always_comb begin
    // sop restarts the byte offset
    base      = i_beat.sop ? '0 : off_q;
    lane_en   = i_beat.eop ? ({`PKT_KEEP_W{1'b1}} >> i_beat.empty)
                           : {`PKT_KEEP_W{1'b1}};
    frame_len = base + `PKT_KEEP_W - i_beat.empty;
    mismatch  = 1'b0;
    // compare every live lane against n + k
    for (int i = 0; i < `PKT_KEEP_W; i++) begin
      if (lane_en[i] && (i_beat.data[8*i +: 8] != idx_q + base[7:0] + 8'(i))) begin
        mismatch = 1'b1;
      end
    end
    // runt frames count as bad too
    bad = err_q || mismatch || (frame_len < `PKT_LEN_MIN);
  end

  always_ff @(posedge app_ss_lite_clk) begin
    if (i_rst) begin
      idx_q     <= '0;
      off_q     <= '0;
      err_q     <= 1'b0;
      o_rx_good <= '0;
      o_rx_bad  <= '0;
    end else if (i_valid) begin
      if (i_beat.eop) begin
        idx_q <= idx_q + 1'b1;
        off_q <= '0;
        err_q <= 1'b0;
        if (bad) begin
          o_rx_bad <= o_rx_bad + 1'b1;
        end else begin
          o_rx_good <= o_rx_good + 1'b1;
        end
      end else begin
        // error sticks until the frame closes
        off_q <= base + `PKT_LEN_W'(`PKT_KEEP_W);
        err_q <= err_q || mismatch;
      end
    end
  end

endmodule

// File: hw/axis_to_avst_rx.sv
// axi-stream to sop-aligned rx bridge with a one-cycle skid stage
`timescale 1ns/1ns
`include "pkt_client_consts.svh"

module axis_to_avst_rx (
  input  logic                       app_ss_lite_clk,
  input  logic                       i_rst,
  input  logic                       i_valid,
  input  pkt_client_pkg::axis_beat_t i_beat,
  output logic                       o_ready,
  output logic                       o_valid,
  output pkt_client_pkg::avst_beat_t o_beat
);

  pkt_client_pkg::avst_beat_t avst_in;
  logic                       sop_next;
  logic [3:0]                 holes;

  always_comb begin
    // unused high lanes on the last beat
    holes = '0;
    for (int i = 0; i < `PKT_KEEP_W; i++) begin
      holes = holes + {3'b0, !i_beat.keep[i]};
    end
    avst_in.data  = i_beat.data;
    avst_in.sop   = sop_next;
    avst_in.eop   = i_beat.last;
    avst_in.empty = i_beat.last ? holes[`PKT_EMPTY_W-1:0] : '0;
  end

  // checker side always ready
  st_pipe_stage #(
    .payload_t (pkt_client_pkg::avst_beat_t)
  ) i_st_pipe_stage (
    .app_ss_lite_clk (app_ss_lite_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_data          (avst_in),
    .o_ready         (o_ready),
    .o_valid         (o_valid),
    .o_data          (o_beat),
    .i_ready         (1'b1)
  );

  // next accepted beat starts a frame after reset or last
  always_ff @(posedge app_ss_lite_clk) begin
    if (i_rst) begin
      sop_next <= 1'b1;
    end else if (i_valid && o_ready) begin
      sop_next <= i_beat.last;
    end
  end

  // partial keep only allowed on the closing beat
  a_keep_full: assert property (@(posedge app_ss_lite_clk) disable iff (i_rst)
    i_valid && !i_beat.last |-> &i_beat.keep)
    else $error("rx keep not full on a non-last beat");

endmodule

// File: hw/avst_to_axis_tx.sv
// sop-aligned to axi-stream tx bridge with a one-cycle skid stage
`timescale 1ns/1ns
`include "pkt_client_consts.svh"

module avst_to_axis_tx (
  input  logic                       app_ss_lite_clk,
  input  logic                       i_rst,
  input  logic                       i_valid,
  input  pkt_client_pkg::avst_beat_t i_beat,
  output logic                       o_ready,
  output logic                       o_valid,
  output pkt_client_pkg::axis_beat_t o_beat,
  input  logic                       i_ready
);

  pkt_client_pkg::axis_beat_t axis_in;
  logic                       in_frame;

  // eop becomes last, empty becomes a low-lane keep mask
  always_comb begin
    axis_in.data = i_beat.data;
    axis_in.last = i_beat.eop;
    axis_in.keep = i_beat.eop ? ({`PKT_KEEP_W{1'b1}} >> i_beat.empty)
                              : {`PKT_KEEP_W{1'b1}};
  end

  st_pipe_stage #(
    .payload_t (pkt_client_pkg::axis_beat_t)
  ) i_st_pipe_stage (
    .app_ss_lite_clk (app_ss_lite_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_data          (axis_in),
    .o_ready         (o_ready),
    .o_valid         (o_valid),
    .o_data          (o_beat),
    .i_ready         (i_ready)
  );

  // open frame tracker on the input side
  always_ff @(posedge app_ss_lite_clk) begin
    if (i_rst) begin
      in_frame <= 1'b0;
    end else if (i_valid && o_ready) begin
      in_frame <= !i_beat.eop;
    end
  end

  // sop exactly on the first beat of each frame
  a_sop_framing: assert property (@(posedge app_ss_lite_clk) disable iff (i_rst)
    i_valid |-> (i_beat.sop != in_frame))
    else $error("tx sop does not match frame boundary");

endmodule

// File: hw/pkt_gen.sv
// patterned frame generator on the sop-aligned tx stream
`timescale 1ns/1ns
`include "pkt_client_consts.svh"

module pkt_gen (
  input  logic                       app_ss_lite_clk,
  input  logic                       i_rst,
  input  pkt_client_pkg::gen_cfg_t   i_cfg,
  output logic                       o_valid,
  output pkt_client_pkg::avst_beat_t o_beat,
  input  logic                       i_ready,
  output logic                       o_busy,
  output logic [`PKT_CNT_W-1:0]      o_tx_frames
);

  logic [`PKT_LEN_W-1:0] len_q;
  logic [`PKT_LEN_W-1:0] len_clamp;
  logic [`PKT_LEN_W-1:0] off_q;
  logic [`PKT_LEN_W-1:0] remain;
  logic [`PKT_LEN_W-1:0] gap;
  logic [`PKT_CNT_W-1:0] left_q;
  logic                  start;
  logic                  accept;

  // start ignored while a run is going
  assign start  = i_cfg.start && !o_busy;
  assign accept = o_valid && i_ready;
  assign o_valid = o_busy;

  // configured length forced into the legal range
  assign len_clamp = (i_cfg.len < `PKT_LEN_MIN) ? `PKT_LEN_W'(`PKT_LEN_MIN) :
                     (i_cfg.len > `PKT_LEN_MAX) ? `PKT_LEN_W'(`PKT_LEN_MAX) : i_cfg.len;

  // ------------------------------------------------------------------
  // beat build
  // ------------------------------------------------------------------
  assign remain = len_q - off_q;
  assign gap    = `PKT_KEEP_W - remain;

  always_comb begin
    o_beat.sop   = (off_q == '0);
    o_beat.eop   = (remain <= `PKT_KEEP_W);
    o_beat.empty = o_beat.eop ? gap[`PKT_EMPTY_W-1:0] : '0;
    // byte k of frame n is n + k, frame index from the tx count
    for (int i = 0; i < `PKT_KEEP_W; i++) begin
      o_beat.data[8*i +: 8] = o_tx_frames[7:0] + off_q[7:0] + 8'(i);
    end
  end

  // ------------------------------------------------------------------
  // frame and offset counters
  // ------------------------------------------------------------------
  always_ff @(posedge app_ss_lite_clk) begin
    if (i_rst) begin
      o_busy      <= 1'b0;
      off_q       <= '0;
      left_q      <= '0;
      o_tx_frames <= '0;
    end else if (start) begin
      // zero frames requested means nothing to send
      o_busy      <= (i_cfg.frames != '0);
      off_q       <= '0;
      left_q      <= i_cfg.frames;
      o_tx_frames <= '0;
    end else if (accept) begin
      if (o_beat.eop) begin
        off_q       <= '0;
        left_q      <= left_q - 1'b1;
        o_tx_frames <= o_tx_frames + 1'b1;
        o_busy      <= (left_q != 1);
      end else begin
        off_q <= off_q + `PKT_LEN_W'(`PKT_KEEP_W);
      end
    end
  end

  always_ff @(posedge app_ss_lite_clk) begin
    if (start) begin
      len_q <= len_clamp;
    end
  end

  // emitted length as seen by the receiver
  a_len_legal: assert property (@(posedge app_ss_lite_clk) disable iff (i_rst)
    o_valid && o_beat.eop |->
      (off_q + `PKT_KEEP_W - o_beat.empty) inside {[`PKT_LEN_MIN:`PKT_LEN_MAX]})
    else $error("generated frame length out of range");

endmodule

// File: hw/st_pipe_stage.sv
// two-entry valid/ready skid stage with a type-parameterised payload
`timescale 1ns/1ns

module st_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     app_ss_lite_clk,
  input  logic     i_rst,
  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_ready,
  output logic     o_valid,
  output payload_t o_data,
  input  logic     i_ready
);

  payload_t skid_data;
  logic     skid_valid;
  logic     out_load;

  // output register free or draining this cycle
  assign out_load = !o_valid || i_ready;
  // ready from a flop only, never from i_ready
  assign o_ready  = !skid_valid;

  always_ff @(posedge app_ss_lite_clk) begin
    if (i_rst) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_load) begin
      // skid beat goes first to keep order
      o_valid    <= skid_valid || i_valid;
      skid_valid <= 1'b0;
    end else if (i_valid && o_ready) begin
      // stalled downstream, park the beat
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge app_ss_lite_clk) begin
    if (out_load) begin
      o_data <= skid_valid ? skid_data : i_data;
    end
    if (!skid_valid) begin
      skid_data <= i_data;
    end
  end

  // producer holds a beat the stage has not taken yet
  a_hold_stable: assert property (@(posedge app_ss_lite_clk) disable iff (i_rst)
    i_valid && !o_ready |=> i_valid && $stable(i_data))
    else $error("pipe stage input changed before it was taken");

endmodule

// File: hw/pkt_client_pkg.sv
// beat, generator config, frame counter and wishbone struct types
`include "pkt_client_consts.svh"

package pkt_client_pkg;

  // sop-aligned beat, lane 0 in the low byte
  typedef struct packed {
    logic [`PKT_DATA_W-1:0]  data;
    logic                    sop;
    logic                    eop;
    logic [`PKT_EMPTY_W-1:0] empty;
  } avst_beat_t;

  // axi-stream beat toward the mac
  typedef struct packed {
    logic [`PKT_DATA_W-1:0] data;
    logic [`PKT_KEEP_W-1:0] keep;
    logic                   last;
  } axis_beat_t;

  // start is a single cycle pulse
  typedef struct packed {
    logic                   start;
    logic [`PKT_CNT_W-1:0]  frames;
    logic [`PKT_LEN_W-1:0]  len;
  } gen_cfg_t;

  typedef struct packed {
    logic [`PKT_CNT_W-1:0] tx_frames;
    logic [`PKT_CNT_W-1:0] rx_good;
    logic [`PKT_CNT_W-1:0] rx_bad;
  } pkt_counts_t;

  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`WB_ADR_W-1:0] adr;
    logic [`WB_DAT_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                 ack;
    logic [`WB_DAT_W-1:0] dat;
  } wb_rsp_t;

endpackage

// File: hw/pkt_client_consts.svh
// stream widths, frame length limits and status register word addresses
`ifndef PKT_CLIENT_CONSTS_SVH
`define PKT_CLIENT_CONSTS_SVH

// stream beat layout, 8 byte lanes
`define PKT_DATA_W   64
`define PKT_EMPTY_W  3
`define PKT_KEEP_W   8

// legal frame lengths in bytes
`define PKT_LEN_MIN  8
`define PKT_LEN_MAX  1518
`define PKT_LEN_W    11
`define PKT_CNT_W    16

// wishbone slave port
`define WB_ADR_W     4
`define WB_DAT_W     32

// register word addresses
`define REG_CTRL     4'd0
`define REG_LEN      4'd1
`define REG_TXCNT    4'd2
`define REG_RXGOOD   4'd3
`define REG_RXBAD    4'd4
`define REG_STAT     4'd5

`endif
